// File: smc_pkg.sv
/* Static memory controller package
   Access phases, bus widths and fixed timing values */
package smc_pkg;

   //------------------------------------------------------------
   // Bus widths
   //------------------------------------------------------------
   localparam int WS_W     = 8;                        // Wait-state store and count
   localparam int TIMING_W = 2;                        // OE trailing-edge setting
   localparam int BE_W     = 4;                        // Byte strobes

   // Byte enables are active low
   localparam logic [BE_W-1:0] BE_IDLE = {BE_W{1'b1}};

   //------------------------------------------------------------
   // Timing constants
   //------------------------------------------------------------
   // Count value of the final read/write cycle
   localparam logic [WS_W-1:0] WS_LAST = '0;

   //------------------------------------------------------------
   // Access phases
   //------------------------------------------------------------
   typedef enum logic [2:0]
   {
      SMC_IDLE  = 3'd0,                                // No access
      SMC_LE    = 3'd1,                                // Leading edge, address setup
      SMC_RW    = 3'd2,                                // Strobes active, wait states
      SMC_FLOAT = 3'd3                                 // Turnaround before next access
   } smc_phase_e;

endpackage

// File: smc_ctrl_if.sv
/* Access control bundle
   Phase, wait count and done from the sequencer to its peer blocks */
`timescale 1ns/1ps

interface smc_ctrl_if
   import smc_pkg::*;
();

   smc_phase_e      current_phase;                     // Registered phase
   smc_phase_e      next_phase;                        // Phase after next edge
   logic [WS_W-1:0] ws_count;                          // RW cycles left after this one
   logic            smc_done;                          // Last RW cycle of the access

   // Sequencer owns every signal
   modport seq
   (
      output current_phase,
      output next_phase,
      output ws_count,
      output smc_done
   );

   // Strobe generator needs the count for the early read release
   modport strobe
   (
      input  current_phase,
      input  next_phase,
      input  ws_count,
      input  smc_done
   );

   // Latch only needs to know when an access starts and ends
   modport latch
   (
      input  current_phase,
      input  next_phase,
      input  smc_done
   );

endinterface

// File: smc_access_seq.sv
/* Access sequencer
   Steps idle, leading edge, read/write and float, and counts wait states */
`timescale 1ns/1ps

module smc_access_seq
   import smc_pkg::*;
(
   input  logic            sys_clk7,                   // System clock
   input  logic            n_sys_reset7,               // Async reset, active low
   input  logic            valid_access,               // Request strobe
   input  logic [WS_W-1:0] ws_store,                   // Wait states for this access
   smc_ctrl_if.seq         ctrl                        // Phase, count and done out
);

   smc_phase_e      state_q;                           // Current phase
   smc_phase_e      state_d;                           // Next phase
   logic [WS_W-1:0] ws_cnt_q;                          // Wait-state down counter
   logic            accept;                            // Request taken this cycle
   logic            last_rw;                           // Final read/write cycle

   // Requests outside idle are dropped
   assign accept  = valid_access && (state_q == SMC_IDLE);
   assign last_rw = (state_q == SMC_RW) && (ws_cnt_q == WS_LAST);

   //------------------------------------------------------------
   // Next phase
   //------------------------------------------------------------
   always_comb
   begin
      state_d = state_q;                               // Default hold
      case (state_q)
         SMC_IDLE:
         begin
            if (accept)
            begin
               state_d = SMC_LE;
            end
         end
         SMC_LE:
         begin
            state_d = SMC_RW;                          // Leading edge is one cycle
         end
         SMC_RW:
         begin
            if (last_rw)
            begin
               state_d = SMC_FLOAT;                    // Wait states used up
            end
         end
         SMC_FLOAT:
         begin
            state_d = SMC_IDLE;
         end
         default:
         begin
            state_d = SMC_IDLE;                        // Recover from bad encoding
         end
      endcase
   end

   //------------------------------------------------------------
   // Phase register
   //------------------------------------------------------------
   always_ff @(posedge sys_clk7 or negedge n_sys_reset7)
   begin
      if (!n_sys_reset7)
      begin
         state_q <= SMC_IDLE;
      end
      else
      begin
         state_q <= state_d;
      end
   end

   //------------------------------------------------------------
   // Wait-state counter
   //------------------------------------------------------------
   // Loaded on acceptance so it also holds ws_store through LE
   // First RW cycle then sees the full count
   // Ends every access at zero
   always_ff @(posedge sys_clk7 or negedge n_sys_reset7)
   begin
      if (!n_sys_reset7)
      begin
         ws_cnt_q <= WS_LAST;
      end
      else if (accept)
      begin
         ws_cnt_q <= ws_store;                         // Sample wait states
      end
      else if ((state_q == SMC_RW) && !last_rw)
      begin
         ws_cnt_q <= ws_cnt_q - 1'b1;                  // One RW cycle spent
      end
   end

   // Drive shared control bundle
   assign ctrl.current_phase = state_q;
   assign ctrl.next_phase    = state_d;
   assign ctrl.ws_count      = ws_cnt_q;
   assign ctrl.smc_done      = last_rw;                // High through last RW cycle

endmodule

// File: smc_access_latch.sv
/* Access latch
   Holds direction, chip select and byte enables for one access */
`timescale 1ns/1ps

module smc_access_latch
   import smc_pkg::*;
(
   input  logic            sys_clk7,                   // System clock
   input  logic            n_sys_reset7,               // Async reset, active low
   input  logic            valid_access,               // Request strobe
   input  logic            n_read,                     // Direction, low for read
   input  logic            cs,                         // Chip select request
   input  logic [BE_W-1:0] n_be,                       // Byte enables, active low
   smc_ctrl_if.latch       ctrl,                       // Phase and done in
   output logic            n_r_read,                   // Held direction
   output logic            r_cs,                       // Held chip select
   output logic [BE_W-1:0] n_r_be                      // Held byte enables
);

   logic accept;                                       // Same condition as sequencer

   assign accept = valid_access && (ctrl.current_phase == SMC_IDLE);

   //------------------------------------------------------------
   // Direction and byte enables
   //------------------------------------------------------------
   // Kept until the next accepted access
   always_ff @(posedge sys_clk7 or negedge n_sys_reset7)
   begin
      if (!n_sys_reset7)
      begin
         n_r_read <= 1'b1;
         n_r_be   <= BE_IDLE;
      end
      else if (accept)
      begin
         n_r_read <= n_read;
         n_r_be   <= n_be;
      end
   end

   //------------------------------------------------------------
   // Chip select
   //------------------------------------------------------------
   always_ff @(posedge sys_clk7 or negedge n_sys_reset7)
   begin
      if (!n_sys_reset7)
      begin
         r_cs <= 1'b0;
      end
      else if (accept)
      begin
         r_cs <= cs;                                   // Covers LE and RW
      end
      else if (ctrl.smc_done)
      begin
         r_cs <= 1'b0;                                 // Drop at end of done cycle
      end
   end

endmodule

// File: smc_strobe_gen.sv
/* External strobe generator
   Registered read, write, bus-driver enable and busy from the next phase */
`timescale 1ns/1ps

module smc_strobe_gen
   import smc_pkg::*;
(
   input  logic                sys_clk7,               // System clock
   input  logic                n_sys_reset7,           // Async reset, active low
   input  logic [TIMING_W-1:0] oete_store,             // Read strobe early release
   smc_ctrl_if.strobe          ctrl,                   // Phase, count and done in
   input  logic                n_r_read,               // Held direction
   input  logic [BE_W-1:0]     n_r_be,                 // Held byte enables
   output logic                smc_n_rd,               // Read strobe, active low
   output logic                smc_n_ext_oe,           // Bus driver enable, active low
   output logic [BE_W-1:0]     n_r_we,                 // Per-byte write enables
   output logic                n_r_wr,                 // Write strobe, active low
   output logic                smc_busy                // Access in progress
);

   logic [WS_W-1:0] oete_ext;                          // Release setting, count width
   logic [WS_W-1:0] next_ws;                           // Count of the coming cycle
   logic            enter_rw;                          // Next cycle is read/write
   logic            first_rw;                          // Next cycle is first RW
   logic            rd_low;                            // Read strobe low next cycle
   logic            wr_low;                            // Write strobes low next cycle

   assign oete_ext = {{(WS_W-TIMING_W){1'b0}}, oete_store};
   assign enter_rw = (ctrl.next_phase == SMC_RW);
   assign first_rw = (ctrl.current_phase == SMC_LE);

   // Counter steps down once per RW cycle, holds through LE
   // No step after done since FLOAT follows
   assign next_ws = ((ctrl.current_phase == SMC_RW) && !ctrl.smc_done) ?
                    ctrl.ws_count - 1'b1 : ctrl.ws_count;

   //------------------------------------------------------------
   // Strobe decode
   //------------------------------------------------------------
   // Read released oete_store cycles before the end
   // First RW cycle is always strobed
   assign rd_low = enter_rw && !n_r_read && (first_rw || (next_ws >= oete_ext));

   // Writes hold for every RW cycle
   assign wr_low = enter_rw && n_r_read;

   //------------------------------------------------------------
   // Busy
   //------------------------------------------------------------
   always_ff @(posedge sys_clk7 or negedge n_sys_reset7)
   begin
      if (!n_sys_reset7)
      begin
         smc_busy <= 1'b0;
      end
      else
      begin
         smc_busy <= (ctrl.next_phase != SMC_IDLE);    // Tracks current_phase
      end
   end

   //------------------------------------------------------------
   // Read strobe
   //------------------------------------------------------------
   always_ff @(posedge sys_clk7 or negedge n_sys_reset7)
   begin
      if (!n_sys_reset7)
      begin
         smc_n_rd <= 1'b1;
      end
      else
      begin
         smc_n_rd <= !rd_low;
      end
   end

   //------------------------------------------------------------
   // Write strobes and bus driver enable
   //------------------------------------------------------------
   // Drivers only on while writing data out
   always_ff @(posedge sys_clk7 or negedge n_sys_reset7)
   begin
      if (!n_sys_reset7)
      begin
         n_r_we       <= BE_IDLE;
         n_r_wr       <= 1'b1;
         smc_n_ext_oe <= 1'b1;
      end
      else if (wr_low)
      begin
         n_r_we       <= n_r_be;                       // Byte lanes of this access
         n_r_wr       <= 1'b0;
         smc_n_ext_oe <= 1'b0;
      end
      else
      begin
         n_r_we       <= BE_IDLE;
         n_r_wr       <= 1'b1;
         smc_n_ext_oe <= 1'b1;
      end
   end

endmodule

// File: smc_top.sv
/* Static memory controller, single chip select
   Sequencer, access latch and strobe generator on one control bundle */
`timescale 1ns/1ps

module smc_top
   import smc_pkg::*;
(
   input  logic                sys_clk7,               // System clock
   input  logic                n_sys_reset7,           // Async reset, active low
   input  logic                valid_access,           // Request strobe
   input  logic                n_read,                 // Direction, low for read
   input  logic                cs,                     // Chip select request
   input  logic [BE_W-1:0]     n_be,                   // Byte enables, active low
   input  logic [WS_W-1:0]     ws_store,               // Wait states
   input  logic [TIMING_W-1:0] oete_store,             // Read strobe early release
   output logic                smc_n_rd,               // Read strobe
   output logic                smc_n_ext_oe,           // Bus driver enable
   output logic [BE_W-1:0]     n_r_we,                 // Per-byte write enables
   output logic                n_r_wr,                 // Write strobe
   output logic                smc_busy,               // Access in progress
   output logic                r_cs,                   // Held chip select
   output logic                smc_done                // Last RW cycle
);

   logic            n_r_read;                          // Latched direction
   logic [BE_W-1:0] n_r_be;                            // Latched byte enables

   // Shared phase bundle
   smc_ctrl_if u_ctrl ();

   //------------------------------------------------------------
   // Blocks
   //------------------------------------------------------------
   smc_access_seq u_access_seq
   (
      .sys_clk7     (sys_clk7),
      .n_sys_reset7 (n_sys_reset7),
      .valid_access (valid_access),
      .ws_store     (ws_store),
      .ctrl         (u_ctrl.seq)
   );

   smc_access_latch u_access_latch
   (
      .sys_clk7     (sys_clk7),
      .n_sys_reset7 (n_sys_reset7),
      .valid_access (valid_access),
      .n_read       (n_read),
      .cs           (cs),
      .n_be         (n_be),
      .ctrl         (u_ctrl.latch),
      .n_r_read     (n_r_read),
      .r_cs         (r_cs),
      .n_r_be       (n_r_be)
   );

   smc_strobe_gen u_strobe_gen
   (
      .sys_clk7     (sys_clk7),
      .n_sys_reset7 (n_sys_reset7),
      .oete_store   (oete_store),
      .ctrl         (u_ctrl.strobe),
      .n_r_read     (n_r_read),
      .n_r_be       (n_r_be),
      .smc_n_rd     (smc_n_rd),
      .smc_n_ext_oe (smc_n_ext_oe),
      .n_r_we       (n_r_we),
      .n_r_wr       (n_r_wr),
      .smc_busy     (smc_busy)
   );

   assign smc_done = u_ctrl.smc_done;                  // Done straight from sequencer

endmodule

// File: smc_asserts.sv
/* Protocol assertions for the static memory controller
   Bound into smc_top to check strobe exclusivity and the done pulse */
`timescale 1ns/1ps

module smc_asserts
(
   input logic sys_clk7,                               // System clock
   input logic n_sys_reset7,                           // Async reset, active low
   input logic smc_n_rd,                               // Read strobe
   input logic n_r_wr,                                 // Write strobe
   input logic smc_n_ext_oe,                           // Bus driver enable
   input logic smc_done                                // Last RW cycle
);

   //------------------------------------------------------------
   // Strobe relations
   //------------------------------------------------------------
   // Never read and write on the bus at once
   rd_wr_exclusive: assert property (
      @(posedge sys_clk7) disable iff (!n_sys_reset7)
      !(!smc_n_rd && !n_r_wr))
   else $error("Read and write strobes low in the same cycle");

   // Drivers only on while the write strobe is low
   oe_follows_wr: assert property (
      @(posedge sys_clk7) disable iff (!n_sys_reset7)
      smc_n_ext_oe == n_r_wr)
   else $error("Bus driver enable differs from write strobe");

   //------------------------------------------------------------
   // Done pulse
   //------------------------------------------------------------
   done_one_cycle: assert property (
      @(posedge sys_clk7) disable iff (!n_sys_reset7)
      smc_done |=> !smc_done)
   else $error("Done held for more than one cycle");

endmodule

// File: tb_smc_top.sv
/* Testbench for the static memory controller
   Random accesses checked against a cycle-count model of the strobes */
`timescale 1ns/1ps

module tb_smc_top
   import smc_pkg::*;
();

   localparam int NUM_ACCESS     = 40;
   localparam int TIMEOUT_CYCLES = NUM_ACCESS * 25 + 100;

   // One request as presented to the DUT
   typedef struct packed
   {
      logic                is_write;
      logic                cs;
      logic [BE_W-1:0]     n_be;
      logic [WS_W-1:0]     ws;
      logic [TIMING_W-1:0] oete;
   } req_t;

   // Expected cycle counts of one access
   typedef struct packed
   {
      int              busy_cycles;
      int              cs_cycles;
      int              rd_cycles;
      int              wr_cycles;
      logic [BE_W-1:0] we_value;
   } expect_t;

   logic                sys_clk7;
   logic                n_sys_reset7;
   logic                valid_access;
   logic                n_read;
   logic                cs;
   logic [BE_W-1:0]     n_be;
   logic [WS_W-1:0]     ws_store;
   logic [TIMING_W-1:0] oete_store;
   logic                smc_n_rd;
   logic                smc_n_ext_oe;
   logic [BE_W-1:0]     n_r_we;
   logic                n_r_wr;
   logic                smc_busy;
   logic                r_cs;
   logic                smc_done;

   integer seed        = 32'hbd380595;
   req_t   req_q[$];                                   // Accepted requests in order
   int     errors      = 0;
   int     checked     = 0;
   int     cycle_count = 0;

   smc_top u_smc_top
   (
      .sys_clk7     (sys_clk7),
      .n_sys_reset7 (n_sys_reset7),
      .valid_access (valid_access),
      .n_read       (n_read),
      .cs           (cs),
      .n_be         (n_be),
      .ws_store     (ws_store),
      .oete_store   (oete_store),
      .smc_n_rd     (smc_n_rd),
      .smc_n_ext_oe (smc_n_ext_oe),
      .n_r_we       (n_r_we),
      .n_r_wr       (n_r_wr),
      .smc_busy     (smc_busy),
      .r_cs         (r_cs),
      .smc_done     (smc_done)
   );

   bind smc_top smc_asserts u_smc_asserts
   (
      .sys_clk7     (sys_clk7),
      .n_sys_reset7 (n_sys_reset7),
      .smc_n_rd     (smc_n_rd),
      .n_r_wr       (n_r_wr),
      .smc_n_ext_oe (smc_n_ext_oe),
      .smc_done     (smc_done)
   );

   initial
   begin
      sys_clk7 = 1'b0;
      forever
      begin
         #5 sys_clk7 = ~sys_clk7;                      // 10 ns period
      end
   end

   //------------------------------------------------------------
   // Reference model
   //------------------------------------------------------------
   function automatic expect_t expected_counts
   (
      input logic                is_write,
      input logic                cs_req,
      input logic [WS_W-1:0]     ws,
      input logic [TIMING_W-1:0] oete,
      input logic [BE_W-1:0]     be
   );
      expect_t e;
      int      rw_cycles;
      int      rd_cycles;
      rw_cycles     = int'(ws) + 1;                    // First RW plus wait states
      e.busy_cycles = rw_cycles + 2;                   // LE and FLOAT around RW
      e.cs_cycles   = cs_req ? rw_cycles + 1 : 0;
      if (is_write)
      begin
         e.rd_cycles = 0;
         e.wr_cycles = rw_cycles;
         e.we_value  = be;
      end
      else
      begin
         rd_cycles   = rw_cycles - int'(oete);         // Early release
         e.rd_cycles = (rd_cycles < 1) ? 1 : rd_cycles;
         e.wr_cycles = 0;
         e.we_value  = BE_IDLE;
      end
      return e;
   endfunction

   task automatic check_count(input string what, input int got, input int want);
      assert (got == want)
      else
      begin
         $display("[ERROR] %0t access %0d %s: %0d cycles, expected %0d",
                  $time, checked, what, got, want);
         errors++;
      end
   endtask

   //------------------------------------------------------------
   // Stimulus
   //------------------------------------------------------------
   // Entered and left 1 ns after a rising edge
   task automatic send_access(input bit extra_req);
      logic [31:0] rnd;
      req_t        req;
      rnd          = $random(seed);
      req.is_write = rnd[0];
      req.cs       = rnd[1];
      req.n_be     = rnd[2 +: BE_W];
      req.ws       = WS_W'(rnd[9:6]);                  // 0 to 15 wait states
      req.oete     = rnd[10 +: TIMING_W];
      while (smc_busy)
      begin
         @(posedge sys_clk7);
         #1;
      end
      repeat (rnd[13:12])
      begin
         @(posedge sys_clk7);                          // Random idle gap
         #1;
      end
      valid_access = 1'b1;
      n_read       = req.is_write;
      cs           = req.cs;
      n_be         = req.n_be;
      ws_store     = req.ws;
      oete_store   = req.oete;
      req_q.push_back(req);
      @(posedge sys_clk7);
      #1;
      valid_access = 1'b0;
      if (extra_req)
      begin
         // Second request during LE is dropped
         // oete_store left unchanged
         rnd          = $random(seed);
         valid_access = 1'b1;
         n_read       = ~req.is_write;
         cs           = rnd[0];
         n_be         = rnd[1 +: BE_W];
         ws_store     = WS_W'(rnd[8:5]);
         @(posedge sys_clk7);
         #1;
         valid_access = 1'b0;
      end
   endtask

   initial
   begin
      int idx;
      n_sys_reset7 = 1'b0;
      valid_access = 1'b0;
      n_read       = 1'b1;
      cs           = 1'b0;
      n_be         = BE_IDLE;
      ws_store     = '0;
      oete_store   = '0;
      repeat (4) @(posedge sys_clk7);
      #1 n_sys_reset7 = 1'b1;
      repeat (3) @(posedge sys_clk7);                  // Idle outputs checked here
      #1;
      for (idx = 0; idx < NUM_ACCESS; idx++)
      begin
         send_access((idx % 4) == 3);
      end
      wait (checked == NUM_ACCESS);
      repeat (2) @(posedge sys_clk7);
      $display("Accesses checked: %0d of %0d, errors: %0d", checked, NUM_ACCESS, errors);
      if (errors == 0)
         $display("Result: PASSED");
      else
         $display("Result: FAILED");
      $finish;
   end

   //------------------------------------------------------------
   // Checker sampling at the falling edge
   //------------------------------------------------------------
   initial
   begin
      expect_t exp;
      req_t    cur;
      logic    busy_prev;
      logic    wr_window;
      int      busy_cnt;
      int      rd_cnt;
      int      wr_cnt;
      int      oe_cnt;
      int      done_cnt;
      int      cs_bad;
      int      we_bad;
      busy_prev = 1'b0;
      exp       = '0;
      wait (n_sys_reset7 === 1'b1);
      forever
      begin
         @(negedge sys_clk7);
         if (smc_busy && !busy_prev)
         begin
            assert (req_q.size() > 0)
            else
            begin
               $display("Access started at %0t without a matching request", $time);
               errors++;
            end
            cur      = (req_q.size() > 0) ? req_q.pop_front() : '0;
            exp      = expected_counts(cur.is_write, cur.cs, cur.ws, cur.oete, cur.n_be);
            busy_cnt = 0;
            rd_cnt   = 0;
            wr_cnt   = 0;
            oe_cnt   = 0;
            done_cnt = 0;
            cs_bad   = 0;
            we_bad   = 0;
         end
         if (smc_busy)
         begin
            // RW cycles of a write follow the single LE cycle
            wr_window = (busy_cnt >= 1) && (busy_cnt <= exp.wr_cycles);
            if (r_cs !== (busy_cnt < exp.cs_cycles))
            begin
               cs_bad++;                               // CS held over LE and RW only
            end
            if (n_r_we !== (wr_window ? exp.we_value : BE_IDLE))
            begin
               we_bad++;                               // Lanes only during write RW
            end
            busy_cnt++;
            if (!smc_n_rd)
            begin
               rd_cnt++;
            end
            if (!n_r_wr)
            begin
               wr_cnt++;
            end
            if (!smc_n_ext_oe)
            begin
               oe_cnt++;
            end
            if (smc_done)
            begin
               done_cnt++;
            end
         end
         else if (busy_prev)
         begin
            check_count("busy", busy_cnt, exp.busy_cycles);
            check_count("read strobe low", rd_cnt, exp.rd_cycles);
            check_count("write strobe low", wr_cnt, exp.wr_cycles);
            check_count("bus driver enable low", oe_cnt, exp.wr_cycles);
            check_count("done high", done_cnt, 1);
            check_count("chip select wrong", cs_bad, 0);
            check_count("byte write enable wrong", we_bad, 0);
            checked++;
         end
         if (!smc_busy)
         begin
            assert (smc_n_rd && n_r_wr && smc_n_ext_oe && !r_cs && !smc_done &&
                    (n_r_we == BE_IDLE))
            else
            begin
               $display("[ERROR] %0t control output active while idle", $time);
               errors++;
            end
         end
         busy_prev = smc_busy;
      end
   end

   //------------------------------------------------------------
   // Timeout
   //------------------------------------------------------------
   initial
   begin
      while (cycle_count < TIMEOUT_CYCLES)
      begin
         @(posedge sys_clk7);
         cycle_count++;
      end
      $display("Timeout: run did not finish in %0d cycles, %0d accesses checked, %0d errors",
               TIMEOUT_CYCLES, checked, errors);
      $display("Result: FAILED");
      $finish;
   end

endmodule

// File: project.f
smc_pkg.sv
smc_ctrl_if.sv
smc_access_seq.sv
smc_access_latch.sv
smc_strobe_gen.sv
smc_top.sv
smc_asserts.sv
tb_smc_top.sv

// File: run.sh
#!/bin/sh
# Build the testbench with Verilator, run it, and look for the pass line in the log
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module tb_smc_top -f project.f \
   && ./obj_dir/Vtb_smc_top | tee sim.log \
   && grep -q "^Result: PASSED$" sim.log \
   && echo "Simulation passed" \
   || { echo "Simulation failed"; exit 1; }
